/* dv/mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb;
    import mips_pkg::*;

    localparam int N_TESTS      = 6;
    localparam int PROG_LEN     = 12;
    localparam int RESET_CYCLES = 5;
    localparam int TEST_CYCLES  = PROG_LEN * 4 + 10;
    localparam int RUN_LIMIT    = N_TESTS * (TEST_CYCLES + RESET_CYCLES + 2);

    logic     clk;
    logic     rst_n;
    word_t    inst_addr, inst, mem_addr, mem_wdata, mem_rdata, wb_data;
    logic     mem_we, wb_we;
    reg_idx_t wb_rd;

    word_t imem [16];
    word_t dmem [16];

    // Test table
    string    test_name [N_TESTS];
    word_t    prog      [N_TESTS][PROG_LEN];
    int       n_store   [N_TESTS];  // Which store carries the result
    word_t    exp_addr  [N_TESTS];
    word_t    exp_data  [N_TESTS];
    reg_idx_t bad_reg   [N_TESTS];  // Register that only a skipped path writes
    int       link_idx  [N_TESTS];  // Register write that must be the JAL link
    word_t    exp_link  [N_TESTS];

    int errors;
    int passed;
    int failed;
    int total_cycles;

    mips_core dut (.*);

    // Both memories answer combinationally
    assign inst      = imem[inst_addr[5:2]];
    assign mem_rdata = dmem[mem_addr[5:2]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[5:2]] <= mem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        total_cycles++;
        if (total_cycles > RUN_LIMIT) begin
            $display("Run exceeded %0d cycles", RUN_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                    logic [4:0] shamt, funct_t fn);
        return {OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t enc_j(opcode_t op, logic [25:0] idx);
        return {op, idx};
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic set_row(int t, string name, int nst, word_t addr, word_t data,
                           reg_idx_t bad, int lidx, word_t link);
        test_name[t] = name;
        n_store[t]   = nst;
        exp_addr[t]  = addr;
        exp_data[t]  = data;
        bad_reg[t]   = bad;
        link_idx[t]  = lidx;
        exp_link[t]  = link;
    endtask

    task automatic build_table();
        for (int t = 0; t < N_TESTS; t++) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                prog[t][i] = '0;
            end
        end
        // R-type ops with back-to-back dependencies
        set_row(0, "rtype", 1, 32'h20, 32'hFFFF_FF31, 5'd0, 0, '0);
        prog[0][0]  = enc_i(OP_ADDIU, 0, 1, 16'd12);
        prog[0][1]  = enc_i(OP_ADDIU, 0, 2, 16'hFFFB);
        prog[0][2]  = enc_r(1, 2, 3, 0, FN_ADDU);   // 7
        prog[0][3]  = enc_r(3, 1, 4, 0, FN_SUBU);   // -5
        prog[0][4]  = enc_r(4, 1, 5, 0, FN_SLT);    // 1
        prog[0][5]  = enc_r(0, 1, 6, 5'd4, FN_SLL); // 0xC0
        prog[0][6]  = enc_r(0, 2, 7, 5'd28, FN_SRL);
        prog[0][7]  = enc_r(6, 7, 8, 0, FN_NOR);
        prog[0][8]  = enc_r(8, 5, 9, 0, FN_XOR);
        prog[0][9]  = enc_r(9, 4, 10, 0, FN_AND);
        prog[0][10] = enc_i(OP_SW, 0, 10, 16'h20);
        prog[0][11] = enc_j(OP_J, 26'd11);
        // Immediate extension rules
        set_row(1, "immediate", 1, 32'h24, 32'hEDCA_6FFF, 5'd0, 0, '0);
        prog[1][0]  = enc_i(OP_ADDIU, 0, 1, 16'h8001);  // sign-extended
        prog[1][1]  = enc_i(OP_ANDI, 1, 2, 16'hF0F1);
        prog[1][2]  = enc_i(OP_ORI, 0, 3, 16'h9000);
        prog[1][3]  = enc_i(OP_XORI, 1, 4, 16'hFFFF);
        prog[1][4]  = enc_i(OP_SLTI, 1, 5, 16'h8000);   // 0 only with sign extension
        prog[1][5]  = enc_i(OP_LUI, 0, 6, 16'h1234);
        prog[1][6]  = enc_r(6, 2, 7, 0, FN_ADDU);
        prog[1][7]  = enc_r(7, 3, 8, 0, FN_ADDU);
        prog[1][8]  = enc_r(8, 4, 9, 0, FN_XOR);
        prog[1][9]  = enc_r(9, 5, 10, 0, FN_ADDU);
        prog[1][10] = enc_i(OP_SW, 0, 10, 16'h24);
        prog[1][11] = enc_j(OP_J, 26'd11);
        // Store, reload, use at once
        set_row(2, "load_store", 2, 32'h28, 32'hA5A5_5A5B, 5'd0, 0, '0);
        prog[2][0]  = enc_i(OP_LUI, 0, 1, 16'hA5A5);
        prog[2][1]  = enc_i(OP_ORI, 1, 1, 16'h5A5A);
        prog[2][2]  = enc_i(OP_SW, 0, 1, 16'h10);
        prog[2][3]  = enc_i(OP_LW, 0, 2, 16'h10);
        prog[2][4]  = enc_i(OP_ADDIU, 2, 3, 16'd1);
        prog[2][5]  = enc_i(OP_SW, 0, 3, 16'h28);
        prog[2][6]  = enc_j(OP_J, 26'd6);
        // Wrongly taken branches land on the self loop at 11
        set_row(3, "branches", 1, 32'h2C, 32'd3, 5'd20, 0, '0);
        prog[3][0]  = enc_i(OP_ADDIU, 0, 1, 16'd3);
        prog[3][1]  = enc_i(OP_ADDIU, 0, 2, 16'd3);
        prog[3][2]  = enc_i(OP_BEQ, 1, 2, 16'd1);
        prog[3][3]  = enc_i(OP_ADDIU, 0, 20, 16'd99);
        prog[3][4]  = enc_i(OP_BNE, 1, 2, 16'd6);
        prog[3][5]  = enc_i(OP_BLEZ, 1, 0, 16'd5);
        prog[3][6]  = enc_i(OP_BGTZ, 1, 0, 16'd1);
        prog[3][7]  = enc_i(OP_ADDIU, 0, 20, 16'd77);
        prog[3][8]  = enc_i(OP_BLEZ, 0, 0, 16'd1);
        prog[3][9]  = enc_i(OP_ADDIU, 0, 20, 16'd55);
        prog[3][10] = enc_i(OP_SW, 0, 2, 16'h2C);
        prog[3][11] = enc_j(OP_J, 26'd11);
        // J over code, JAL to a subroutine, JR back
        set_row(4, "jumps", 1, 32'h30, 32'd16, 5'd20, 2, 32'd16);
        prog[4][0]  = enc_i(OP_ADDIU, 0, 1, 16'd5);
        prog[4][1]  = enc_j(OP_J, 26'd3);
        prog[4][2]  = enc_i(OP_ADDIU, 0, 20, 16'd1);
        prog[4][3]  = enc_j(OP_JAL, 26'd6);
        prog[4][4]  = enc_i(OP_ADDIU, 1, 2, 16'd10);
        prog[4][5]  = enc_j(OP_J, 26'd8);
        prog[4][6]  = enc_i(OP_ADDIU, 1, 1, 16'd1);
        prog[4][7]  = enc_r(31, 0, 0, 0, FN_JR);
        prog[4][8]  = enc_i(OP_SW, 0, 2, 16'h30);
        prog[4][9]  = enc_j(OP_J, 26'd9);
        // Opposite branch outcomes on a negative operand, wrong path ends at 8
        set_row(5, "branches_neg", 1, 32'h34, 32'hFFFF_FFFD, 5'd20, 0, '0);
        prog[5][0]  = enc_i(OP_ADDIU, 0, 1, 16'hFFFD);
        prog[5][1]  = enc_i(OP_BEQ, 1, 0, 16'd6);
        prog[5][2]  = enc_i(OP_BNE, 1, 0, 16'd1);
        prog[5][3]  = enc_i(OP_ADDIU, 0, 20, 16'd1);
        prog[5][4]  = enc_i(OP_BGTZ, 1, 0, 16'd3);
        prog[5][5]  = enc_i(OP_BLEZ, 1, 0, 16'd1);
        prog[5][6]  = enc_i(OP_ADDIU, 0, 20, 16'd2);
        prog[5][7]  = enc_i(OP_SW, 0, 1, 16'h34);
        prog[5][8]  = enc_j(OP_J, 26'd8);
    endtask

    task automatic run_test(int t);
        int cycles;
        int writes;
        int stores;
        int errors_before;
        bit done;

        errors_before = errors;
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            imem[i] = (i < PROG_LEN) ? prog[t][i] : '0;
            dmem[i] = $urandom;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("inst_addr", inst_addr, RESET_PC);
        check_bit("mem_we", mem_we, 1'b0);
        check_bit("wb_we", wb_we, 1'b0);

        cycles = 0;
        writes = 0;
        stores = 0;
        done   = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (wb_we) begin
                writes++;
                if (bad_reg[t] != '0 && wb_rd == bad_reg[t]) begin
                    $display("Register %0d written on a path that must be skipped", wb_rd);
                    errors++;
                end
                if (writes == link_idx[t]) begin
                    check_reg("wb_rd", wb_rd, LINK_REG);
                    check_word("wb_data", wb_data, exp_link[t]);
                end
            end
            if (mem_we) begin
                stores++;
                if (stores == n_store[t]) begin
                    check_word("mem_addr", mem_addr, exp_addr[t]);
                    check_word("mem_wdata", mem_wdata, exp_data[t]);
                    done = 1;
                end
            end
            if (!done && cycles >= TEST_CYCLES) begin
                $display("No result store within %0d cycles", TEST_CYCLES);
                errors++;
                done = 1;
            end
        end

        if (errors == errors_before) begin
            $display("%s: pass", test_name[t]);
            passed++;
        end else begin
            $display("%s: FAIL", test_name[t]);
            failed++;
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        total_cycles = 0;
        void'($urandom(63));
        build_table();
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  mips_pkg::word_t   input1,
    input  mips_pkg::word_t   input2,
    input  mips_pkg::alu_op_t alu_operation,
    output mips_pkg::word_t   out,
    output logic              zero,
    output logic              negative
);
    import mips_pkg::*;

    word_t diff;

    // Flags always describe input1 - input2, for branch resolution
    assign diff     = input1 - input2;
    assign zero     = (diff == '0);
    assign negative = $signed(input1) < $signed(input2);  // No overflow wrap

    always_comb begin
        case (alu_operation)
            ALU_ADD: out = input1 + input2;
            ALU_SUB: out = diff;
            ALU_AND: out = input1 & input2;
            ALU_OR:  out = input1 | input2;
            ALU_XOR: out = input1 ^ input2;
            ALU_NOR: out = ~(input1 | input2);
            ALU_SLT: out = {31'b0, negative};
            ALU_SLL: out = input2 << input1[4:0];
            ALU_SRL: out = input2 >> input1[4:0];
            ALU_LUI: out = {input2[15:0], 16'b0};
            default: out = '0;
        endcase
    end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  mips_pkg::word_t   inst,
    output logic              reg_dest,
    output logic              reg_write_enable,
    output logic              alu_src,
    output logic              mem_or_reg,
    output logic              mem_write,
    output logic              pc_or_mem,
    output logic              should_branch,
    output logic              jump,
    output logic              jump_register,
    output logic              does_shift_amount_need,
    output logic              is_unsigned,
    output logic              uses_rt,
    output mips_pkg::alu_op_t alu_operation
);
    import mips_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        reg_dest               = 1'b0;
        reg_write_enable       = 1'b0;
        alu_src                = 1'b0;
        mem_or_reg             = 1'b0;
        mem_write              = 1'b0;
        pc_or_mem              = 1'b0;
        should_branch          = 1'b0;
        jump                   = 1'b0;
        jump_register          = 1'b0;
        does_shift_amount_need = 1'b0;
        is_unsigned            = 1'b0;
        uses_rt                = 1'b0;
        alu_operation          = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                reg_dest         = 1'b1;
                reg_write_enable = 1'b1;
                uses_rt          = 1'b1;
                case (funct)
                    FN_ADDU: alu_operation = ALU_ADD;
                    FN_SUBU: alu_operation = ALU_SUB;
                    FN_AND:  alu_operation = ALU_AND;
                    FN_OR:   alu_operation = ALU_OR;
                    FN_XOR:  alu_operation = ALU_XOR;
                    FN_NOR:  alu_operation = ALU_NOR;
                    FN_SLT:  alu_operation = ALU_SLT;
                    FN_SLL, FN_SRL: begin
                        alu_operation          = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        does_shift_amount_need = 1'b1;  // shamt into ALU input1
                    end
                    FN_JR: begin
                        reg_dest         = 1'b0;
                        reg_write_enable = 1'b0;
                        uses_rt          = 1'b0;
                        jump_register    = 1'b1;
                    end
                    default: begin
                        // Unknown funct acts as a no-op
                        reg_dest         = 1'b0;
                        reg_write_enable = 1'b0;
                        uses_rt          = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_SLTI, OP_LUI: begin
                alu_src          = 1'b1;
                reg_write_enable = 1'b1;
                alu_operation    = (opcode == OP_ADDIU) ? ALU_ADD :
                                   (opcode == OP_SLTI)  ? ALU_SLT : ALU_LUI;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                alu_src          = 1'b1;
                reg_write_enable = 1'b1;
                is_unsigned      = 1'b1;  // Logical immediates zero-extend
                alu_operation    = (opcode == OP_ANDI) ? ALU_AND :
                                   (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LW: begin
                alu_src          = 1'b1;
                reg_write_enable = 1'b1;
                mem_or_reg       = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                uses_rt   = 1'b1;  // Store data
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                should_branch = 1'b1;
                alu_operation = ALU_SUB;
                uses_rt       = (opcode == OP_BEQ) || (opcode == OP_BNE);
            end
            OP_J:   jump = 1'b1;
            OP_JAL: begin
                jump             = 1'b1;
                reg_write_enable = 1'b1;
                pc_or_mem        = 1'b1;  // Link value is PC + 4
            end
            default: ;
        endcase
    end

endmodule

/* hdl/data_path.sv */
`timescale 1ns/1ps

module data_path (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::word_t    inst,
    output mips_pkg::word_t    inst_addr,
    output mips_pkg::word_t    mem_addr,
    output mips_pkg::word_t    mem_wdata,
    output logic               mem_we,
    input  mips_pkg::word_t    mem_rdata,
    output mips_pkg::word_t    inst_id,
    input  logic               reg_dest,
    input  logic               reg_write_enable,
    input  logic               alu_src,
    input  mips_pkg::alu_op_t  alu_operation,
    input  logic               mem_or_reg,
    input  logic               mem_write,
    input  logic               pc_or_mem,
    input  logic               should_branch,
    input  logic               jump,
    input  logic               jump_register,
    input  logic               does_shift_amount_need,
    input  logic               is_unsigned,
    input  logic               stall,
    input  logic               flush,
    output mips_pkg::reg_idx_t rs_id,
    output mips_pkg::reg_idx_t rt_id,
    output mips_pkg::reg_idx_t rd_ex,
    output mips_pkg::reg_idx_t rd_mem,
    output logic               we_ex,
    output logic               we_mem,
    output logic               redirect_mem,
    output logic               wb_we,
    output mips_pkg::reg_idx_t wb_rd,
    output mips_pkg::word_t    wb_data
);
    import mips_pkg::*;

    word_t    pc, pc4_if, redirect_pc;
    logic     valid_id, valid_ex, valid_mem, valid_wb;
    word_t    pc4_id, rs_data_id, rt_data_id, imm_id, br_target_id, j_target_id;
    reg_idx_t dest_id;
    logic     reg_write_ex, alu_src_ex, mem_or_reg_ex, mem_write_ex, pc_or_mem_ex;
    logic     branch_ex, jump_ex, jr_ex, shift_ex, zero_ex, negative_ex;
    alu_op_t  alu_op_ex;
    opcode_t  opcode_ex, opcode_mem;
    logic [4:0] shamt_ex;
    word_t    pc4_ex, rs_data_ex, rt_data_ex, imm_ex, br_target_ex, j_target_ex;
    word_t    alu_in1, alu_in2, alu_out_ex;
    logic     reg_write_mem, mem_or_reg_mem, mem_write_mem, pc_or_mem_mem;
    logic     branch_mem, jump_mem, jr_mem, zero_mem, negative_mem, branch_taken;
    word_t    pc4_mem, rs_data_mem, rt_data_mem, alu_mem, br_target_mem, j_target_mem;
    logic     reg_write_wb, mem_or_reg_wb, pc_or_mem_wb;
    word_t    pc4_wb, alu_wb, load_wb;

    assign inst_addr = pc;
    assign pc4_if    = pc + 32'd4;

    // Control state: PC, valid bits and the decode instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= RESET_PC;
            valid_id  <= 1'b0;
            inst_id   <= '0;
            valid_ex  <= 1'b0;
            valid_mem <= 1'b0;
            valid_wb  <= 1'b0;
        end else begin
            if (flush) begin
                pc       <= redirect_pc;
                valid_id <= 1'b0;
                inst_id  <= '0;  // NOP
            end else if (!stall) begin
                pc       <= pc4_if;
                valid_id <= 1'b1;
                inst_id  <= inst;
            end
            valid_ex  <= valid_id && !stall && !flush;  // Bubble on stall
            valid_mem <= valid_ex && !flush;
            valid_wb  <= valid_mem;
        end
    end

    // Decode
    assign rs_id        = jump ? '0 : inst_id[25:21];  // Target bits, not a source
    assign rt_id        = inst_id[20:16];
    assign imm_id       = is_unsigned ? {16'b0, inst_id[15:0]} : {{16{inst_id[15]}}, inst_id[15:0]};
    assign br_target_id = pc4_id + {{14{inst_id[15]}}, inst_id[15:0], 2'b00};
    assign j_target_id  = {pc4_id[31:28], inst_id[25:0], 2'b00};
    assign dest_id      = pc_or_mem ? LINK_REG : (reg_dest ? inst_id[15:11] : inst_id[20:16]);

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_num  (inst_id[25:21]),
        .rt_num  (inst_id[20:16]),
        .rd_num  (wb_rd),
        .rd_data (wb_data),
        .rd_we   (wb_we),
        .rs_data (rs_data_id),
        .rt_data (rt_data_id)
    );

    // Stage payload, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc4_id <= pc4_if;
        end
        reg_write_ex  <= reg_write_enable;
        alu_src_ex    <= alu_src;
        mem_or_reg_ex <= mem_or_reg;
        mem_write_ex  <= mem_write;
        pc_or_mem_ex  <= pc_or_mem;
        branch_ex     <= should_branch;
        jump_ex       <= jump;
        jr_ex         <= jump_register;
        shift_ex      <= does_shift_amount_need;
        alu_op_ex     <= alu_operation;
        opcode_ex     <= inst_id[31:26];
        shamt_ex      <= inst_id[10:6];
        rd_ex         <= dest_id;
        pc4_ex        <= pc4_id;
        rs_data_ex    <= rs_data_id;
        rt_data_ex    <= rt_data_id;
        imm_ex        <= imm_id;
        br_target_ex  <= br_target_id;
        j_target_ex   <= j_target_id;

        reg_write_mem  <= reg_write_ex;
        mem_or_reg_mem <= mem_or_reg_ex;
        mem_write_mem  <= mem_write_ex;
        pc_or_mem_mem  <= pc_or_mem_ex;
        branch_mem     <= branch_ex;
        jump_mem       <= jump_ex;
        jr_mem         <= jr_ex;
        zero_mem       <= zero_ex;
        negative_mem   <= negative_ex;
        opcode_mem     <= opcode_ex;
        rd_mem         <= rd_ex;
        pc4_mem        <= pc4_ex;
        rs_data_mem    <= rs_data_ex;
        rt_data_mem    <= rt_data_ex;
        alu_mem        <= alu_out_ex;
        br_target_mem  <= br_target_ex;
        j_target_mem   <= j_target_ex;

        reg_write_wb  <= reg_write_mem;
        mem_or_reg_wb <= mem_or_reg_mem;
        pc_or_mem_wb  <= pc_or_mem_mem;
        wb_rd         <= rd_mem;
        pc4_wb        <= pc4_mem;
        alu_wb        <= alu_mem;
        load_wb       <= mem_rdata;
    end

    // Execute
    assign alu_in1 = shift_ex ? {27'b0, shamt_ex} : rs_data_ex;
    assign alu_in2 = alu_src_ex ? imm_ex : rt_data_ex;
    assign we_ex   = valid_ex && reg_write_ex;

    alu u_alu (
        .input1        (alu_in1),
        .input2        (alu_in2),
        .alu_operation (alu_op_ex),
        .out           (alu_out_ex),
        .zero          (zero_ex),
        .negative      (negative_ex)
    );

    // Memory stage and branch resolution
    always_comb begin
        branch_taken = 1'b0;
        if (branch_mem) begin
            case (opcode_mem)
                OP_BEQ:  branch_taken = zero_mem;
                OP_BNE:  branch_taken = !zero_mem;
                OP_BLEZ: branch_taken = zero_mem || negative_mem;
                OP_BGTZ: branch_taken = !zero_mem && !negative_mem;
                default: branch_taken = 1'b0;
            endcase
        end
    end

    assign redirect_mem = valid_mem && (branch_taken || jump_mem || jr_mem);
    assign redirect_pc  = jr_mem ? rs_data_mem : (jump_mem ? j_target_mem : br_target_mem);
    assign we_mem       = valid_mem && reg_write_mem;
    assign mem_addr     = alu_mem;
    assign mem_wdata    = rt_data_mem;
    assign mem_we       = valid_mem && mem_write_mem;

    // Writeback
    assign wb_we   = valid_wb && reg_write_wb && (wb_rd != '0);
    assign wb_data = pc_or_mem_wb ? pc4_wb : (mem_or_reg_wb ? load_wb : alu_wb);

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::reg_idx_t rs_id,
    input  mips_pkg::reg_idx_t rt_id,
    input  logic               uses_rt_id,
    input  mips_pkg::reg_idx_t rd_ex,
    input  mips_pkg::reg_idx_t rd_mem,
    input  logic               we_ex,
    input  logic               we_mem,
    input  logic               redirect_mem,
    output logic               stall,
    output logic               flush
);

    logic rs_hit;
    logic rt_hit;

    // Producer still in EX or MEM; WB is covered by the register file bypass
    assign rs_hit = (rs_id != '0) &&
                    ((we_ex && rd_ex == rs_id) || (we_mem && rd_mem == rs_id));
    assign rt_hit = uses_rt_id && (rt_id != '0) &&
                    ((we_ex && rd_ex == rt_id) || (we_mem && rd_mem == rt_id));

    assign flush = redirect_mem;
    assign stall = (rs_hit || rt_hit) && !redirect_mem;  // Redirect wins

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic               clk,
    input  logic               rst_n,
    output mips_pkg::word_t    inst_addr,
    input  mips_pkg::word_t    inst,
    output mips_pkg::word_t    mem_addr,
    output mips_pkg::word_t    mem_wdata,
    output logic               mem_we,
    input  mips_pkg::word_t    mem_rdata,
    output logic               wb_we,
    output mips_pkg::reg_idx_t wb_rd,
    output mips_pkg::word_t    wb_data
);
    import mips_pkg::*;

    word_t    inst_id;
    logic     reg_dest, reg_write_enable, alu_src, mem_or_reg, mem_write, pc_or_mem;
    logic     should_branch, jump, jump_register, does_shift_amount_need, is_unsigned;
    logic     uses_rt;
    alu_op_t  alu_operation;
    reg_idx_t rs_id, rt_id, rd_ex, rd_mem;
    logic     we_ex, we_mem, redirect_mem;
    logic     stall, flush;

    // Decodes the instruction held in the decode stage
    control_unit u_control_unit (
        .inst (inst_id),
        .*
    );

    hazard_unit u_hazard_unit (
        .uses_rt_id (uses_rt),
        .*
    );

    data_path u_data_path (.*);

endmodule

/* hdl/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  alu_op_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_BLEZ  = 6'b000110;
    localparam opcode_t OP_BGTZ  = 6'b000111;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;

    // R-type funct field
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_JR   = 6'b001000;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_NOR = 4'd5;
    localparam alu_op_t ALU_SLT = 4'd6;
    localparam alu_op_t ALU_SLL = 4'd7;
    localparam alu_op_t ALU_SRL = 4'd8;
    localparam alu_op_t ALU_LUI = 4'd9;

    localparam word_t    RESET_PC = 32'h0000_0000;
    localparam reg_idx_t LINK_REG = 5'd31;  // JAL writes here

endpackage

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::reg_idx_t rs_num,
    input  mips_pkg::reg_idx_t rt_num,
    input  mips_pkg::reg_idx_t rd_num,
    input  mips_pkg::word_t    rd_data,
    input  logic               rd_we,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data
);
    import mips_pkg::*;

    word_t regs [32];
    logic  wr_live;

    assign wr_live = rd_we && (rd_num != '0);  // r0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_num] <= rd_data;
        end
    end

    // Write before read
    assign rs_data = (wr_live && rd_num == rs_num) ? rd_data : regs[rs_num];
    assign rt_data = (wr_live && rd_num == rt_num) ? rd_data : regs[rt_num];

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module mips_core_tb -o mips_core_sim

out=$(./obj_dir/mips_core_sim)
echo "$out"

# Pass only when the pass line is present
echo "$out" | grep -q "^All checks passed$"

/* sim.f */
hdl/mips_pkg.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/regfile.sv
hdl/hazard_unit.sv
hdl/data_path.sv
hdl/mips_core.sv
dv/mips_core_tb.sv
